// File: filelist.f
+incdir+.
ser_link_pkg.sv
link_ctrl.sv
piso_word_sel.sv
sipo_word_capture.sv
ser_link_top.sv
ser_link_props.sv
ser_link_tb.sv

// File: link_ctrl.sv
/*
 * Gearbox link control
 * Runs the one-hot word counter, decides when a narrow word may cross the
 * link, and drives the input handshake and the output register load strobe.
 * A wide word completes on the input only when its last narrow word leaves.
 */
`timescale 1ns/10ps
`include "ser_link_config.svh"

module link_ctrl (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               v_i,
  input  logic               ready_and_i,
  input  logic               out_full_i,
  output logic               ready_and_o,
  output logic               link_adv_o,
  output logic               last_word_o,
  output logic [`SL_ELS-1:0] count_oh_o,
  output logic               load_out_o
);

  // Counter value that points at word 0
  localparam logic [`SL_ELS-1:0] first_word_lp = {{(`SL_ELS-1){1'b0}}, 1'b1};

  ser_link_pkg::link_state_e state_r;
  ser_link_pkg::link_state_e state_n;

  logic [`SL_ELS-1:0] count_r;
  logic [`SL_ELS-1:0] count_n;
  logic [`SL_ELS-1:0] count_step;
  logic               may_take;
  logic               in_done;

  assign last_word_o = count_r[`SL_ELS-1];

  // Next one-hot position, the counter never steps past the last word
  assign count_step = {count_r[`SL_ELS-2:0], 1'b0};

  // Only the last word needs room in the output register
  // Earlier words go into the assembly register, which is always free for them
  assign may_take = ~(last_word_o & out_full_i & ~ready_and_i);

  assign link_adv_o = v_i & may_take;

  // Ready follows the link decision on the last word, as in a passthrough PISO
  assign ready_and_o = last_word_o & may_take;
  assign in_done     = v_i & ready_and_o;

  // The last word and the assembled words are written to the output together
  assign load_out_o = in_done;

  assign count_oh_o = count_r;

  always_comb
  begin
    state_n = state_r;
    count_n = count_r;
    case (state_r)
      ser_link_pkg::LINK_IDLE:
      begin
        // Word 0 always fits, so a valid input starts moving at once
        if (link_adv_o)
        begin
          state_n = ser_link_pkg::LINK_SEND;
          count_n = count_step;
        end
      end
      ser_link_pkg::LINK_SEND:
      begin
        if (in_done)
        begin
          state_n = ser_link_pkg::LINK_IDLE;
          count_n = first_word_lp;
        end
        else if (link_adv_o)
          count_n = count_step;
        else if (v_i & last_word_o)
          state_n = ser_link_pkg::LINK_FULL;
      end
      ser_link_pkg::LINK_FULL:
      begin
        // Parked on the last word until the output register is read
        if (in_done)
        begin
          state_n = ser_link_pkg::LINK_IDLE;
          count_n = first_word_lp;
        end
      end
      default:
      begin
        state_n = ser_link_pkg::LINK_IDLE;
        count_n = first_word_lp;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r <= ser_link_pkg::LINK_IDLE;
      count_r <= first_word_lp;
    end
    else
    begin
      state_r <= state_n;
      count_r <= count_n;
    end
  end

endmodule

// File: piso_word_sel.sv
/*
 * Serializer word select
 * Picks the narrow word named by the one-hot counter out of the held wide
 * input word. The word array is reversed first when the top word goes first.
 */
`timescale 1ns/10ps
`include "ser_link_config.svh"

module piso_word_sel #(
  parameter int width_p    = `SL_WIDTH,
  parameter int els_p      = `SL_ELS,
  parameter bit hi_to_lo_p = 1'b0
) (
  input  ser_link_pkg::wide_t   data_i,
  input  logic [els_p-1:0]      count_oh_i,
  output ser_link_pkg::narrow_t word_o
);

  logic [els_p-1:0][width_p-1:0] data_li;
  logic [width_p-1:0]            sel_word;

  // Reorder so that counter position 0 always names the first word to send
  if (hi_to_lo_p)
  begin : g_hi2lo
    for (genvar i = 0; i < els_p; i++)
    begin : g_rev
      assign data_li[i] = data_i[els_p-1-i];
    end
  end
  else
  begin : g_lo2hi
    assign data_li = data_i;
  end

  // AND-OR mux, the select is one-hot so at most one term is non-zero
  always_comb
  begin
    sel_word = '0;
    for (int i = 0; i < els_p; i++)
    begin
      sel_word = sel_word | (data_li[i] & {width_p{count_oh_i[i]}});
    end
  end

  assign word_o = sel_word;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the gearbox testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module ser_link_tb -o ser_link_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/ser_link_sim > sim.log 2>&1

grep -qx "RESULT: PASS" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// File: ser_link_config.svh
/*
 * Narrow-link gearbox configuration
 * Sets the link word width, the number of words in a wide transaction
 * and the order in which the words cross the link
 */
`ifndef SER_LINK_CONFIG_SVH
`define SER_LINK_CONFIG_SVH

// Width in bits of one narrow word on the internal link
`define SL_WIDTH 8

// Number of narrow words in one wide word, never below 2
`define SL_ELS 4

// Link word order. A value of 0 sends word 0 first and 1 sends the top word first
`define SL_HI_TO_LO 0

`endif

// File: ser_link_pkg.sv
/*
 * Narrow-link gearbox types
 * Narrow link word, wide transaction word and the control FSM states
 */
`include "ser_link_config.svh"

package ser_link_pkg;

  // One word as it travels across the narrow link
  typedef logic [`SL_WIDTH-1:0] narrow_t;

  // A full transaction, element 0 being the lowest narrow word
  typedef narrow_t [`SL_ELS-1:0] wide_t;

  // Control FSM of the serializer
  // IDLE waits on word 0 for a new transaction
  // SEND is moving words across the link
  // FULL is parked on the last word because the output register cannot take it
  typedef enum logic [1:0] {
    LINK_IDLE,
    LINK_SEND,
    LINK_FULL
  } link_state_e;

endpackage

// File: ser_link_props.sv
/*
 * Gearbox handshake properties
 * Bound to the top level. Checks that the input channel is held for a whole
 * transaction, that the output holds while stalled and that reset clears v_o.
 */
`timescale 1ns/10ps

module ser_link_props (
  input logic                clk_i,
  input logic                rst_i,
  input logic                v_i,
  input ser_link_pkg::wide_t data_i,
  input logic                ready_and_o,
  input logic                v_o,
  input ser_link_pkg::wide_t data_o,
  input logic                ready_and_i
);

  // A started transaction keeps v_i up until the last word is taken
  v_i_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    v_i && !ready_and_o |=> v_i)
    else $error("v_i dropped before the input handshake completed");

  // The serializer reads data_i word by word, so it may not move mid-transaction
  data_i_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    v_i && !ready_and_o |=> $stable(data_i))
    else $error("data_i changed before the input handshake completed");

  // Output register keeps its word until the consumer takes it
  out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    v_o && !ready_and_i |=> v_o && $stable(data_o))
    else $error("v_o or data_o changed while the output was stalled");

  out_reset: assert property (@(posedge clk_i) rst_i |=> !v_o)
    else $error("v_o was high after a reset cycle");

endmodule

bind ser_link_top ser_link_props ser_link_props_inst (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .v_i         (v_i),
  .data_i      (data_i),
  .ready_and_o (ready_and_o),
  .v_o         (v_o),
  .data_o      (data_o),
  .ready_and_i (ready_and_i)
);

// File: ser_link_tb.sv
/*
 * Gearbox testbench
 * Reads transactions from the test data file, drives the input channel,
 * stalls the output channel as each line asks and checks the round trip,
 * the link word order, the handshake timing and the back-pressure rules.
 */
`timescale 1ns/10ps
`include "ser_link_config.svh"

module ser_link_tb;

  localparam int num_trans_lp = 16;
  localparam int timeout_lp   = 200;
  localparam int wide_bits_lp = `SL_WIDTH * `SL_ELS;

  logic                  clk_i;
  logic                  rst_i;
  logic                  v_i;
  ser_link_pkg::wide_t   data_i;
  logic                  ready_and_o;
  logic                  v_o;
  ser_link_pkg::wide_t   data_o;
  logic                  ready_and_i;
  logic                  link_v_o;
  ser_link_pkg::narrow_t link_data_o;

  // Each transaction takes three entries, the wide word, the idle gap and the output stall
  logic [wide_bits_lp-1:0] stim_mem [0:3*num_trans_lp-1];

  int cycle_cnt = 0;
  int stall_cnt;
  int rx_cnt = 0;

  ser_link_top ser_link_top_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .v_i         (v_i),
    .data_i      (data_i),
    .ready_and_o (ready_and_o),
    .v_o         (v_o),
    .data_o      (data_o),
    .ready_and_i (ready_and_i),
    .link_v_o    (link_v_o),
    .link_data_o (link_data_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Counts rising edges so that handshake latency can be measured in cycles
  always @(posedge clk_i)
    cycle_cnt <= cycle_cnt + 1;

  // Output handshakes as they happen on the DUT ports
  always @(posedge clk_i)
  begin
    if (!rst_i && v_o && ready_and_i)
      rx_cnt <= rx_cnt + 1;
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout after %0d cycles while waiting for %s", timeout_lp, what);
    $display("RESULT: FAIL");
    $fatal(1, "Stopping on a timeout");
  endtask

  // Nothing may be valid or ready while reset is held or just after it
  task automatic check_reset_state();
    for (int i = 0; i < 8; i++)
    begin
      @(posedge clk_i);
      #5;
      check_value("v_o in reset", 0, v_o);
      check_value("link_v_o in reset", 0, link_v_o);
      check_value("ready_and_o in reset", 0, ready_and_o);
    end
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("v_o after reset", 0, v_o);
    check_value("link_v_o after reset", 0, link_v_o);
    check_value("ready_and_o after reset", 0, ready_and_o);
  endtask

  task automatic drive_inputs();
    int   gap;
    int   start_cyc;
    int   wait_cyc;
    logic unstalled;
    @(posedge clk_i);
    #5;
    for (int t = 0; t < num_trans_lp; t++)
    begin
      gap = int'(stim_mem[3*t+1]) + int'($urandom % 3);
      // The output is free for this line only if the previous one was read at once
      unstalled = (t == 0) ? 1'b1 : (stim_mem[3*(t-1)+2] == 0);
      if (gap > 0)
      begin
        v_i = 1'b0;
        repeat (gap)
        begin
          @(posedge clk_i);
          #5;
        end
      end
      v_i = 1'b1;
      data_i = stim_mem[3*t];
      start_cyc = cycle_cnt;
      wait_cyc = 0;
      @(negedge clk_i);
      while (!ready_and_o)
      begin
        wait_cyc++;
        if (wait_cyc > timeout_lp)
          report_timeout("ready_and_o");
        @(negedge clk_i);
      end
      if (unstalled)
        check_value("ready_and_o latency", `SL_ELS - 1, cycle_cnt - start_cyc);
      @(posedge clk_i);
      #5;
      // The wide word lands in the output register on the edge after its last word
      if (unstalled)
      begin
        check_value("v_o after last word", 1, v_o);
        check_value("data_o after last word", stim_mem[3*t], data_o);
      end
    end
    v_i = 1'b0;
  endtask

  task automatic receive_outputs();
    int stall;
    int wait_cyc;
    for (int t = 0; t < num_trans_lp; t++)
    begin
      stall = int'(stim_mem[3*t+2]);
      @(posedge clk_i);
      #5;
      ready_and_i = (stall == 0);
      wait_cyc = 0;
      @(negedge clk_i);
      while (!v_o)
      begin
        wait_cyc++;
        if (wait_cyc > timeout_lp)
          report_timeout("v_o");
        @(negedge clk_i);
      end
      // Hold the output off for the number of cycles the line asks for
      if (stall > 0)
      begin
        repeat (stall) @(posedge clk_i);
        #5;
        ready_and_i = 1'b1;
        @(negedge clk_i);
        check_value("v_o held during stall", 1, v_o);
      end
      check_value("data_o", stim_mem[3*t], data_o);
    end
    @(posedge clk_i);
    #5;
    ready_and_i = 1'b0;
  endtask

  // Follows the link one cycle at a time with its own word position
  task automatic watch_link();
    int                    k;
    int                    t;
    int                    idle;
    int                    idx;
    logic                  last;
    logic                  blocked;
    logic                  out_held;
    logic [`SL_WIDTH-1:0]  exp_word;
    k = 0;
    t = 0;
    idle = 0;
    out_held = 1'b0;
    while (t < num_trans_lp)
    begin
      @(negedge clk_i);
      last = (k == `SL_ELS - 1);
      check_value("v_o", out_held, v_o);
      // Only the last word waits, and only on a full output that is not being read
      blocked = last && out_held && !ready_and_i;
      check_value("link_v_o", v_i && !blocked, link_v_o);
      check_value("ready_and_o", last && !blocked, ready_and_o);
      // The output register fills when a last word crosses and empties when it is read
      out_held = (v_i && last && !blocked) || (out_held && !ready_and_i);
      if (v_i && !link_v_o)
        stall_cnt++;
      if (link_v_o)
      begin
        idx = (`SL_HI_TO_LO != 0) ? (`SL_ELS - 1 - k) : k;
        exp_word = stim_mem[3*t][idx*`SL_WIDTH +: `SL_WIDTH];
        check_value("link word", exp_word, link_data_o);
        idle = 0;
        if (last)
        begin
          k = 0;
          t++;
        end
        else
          k++;
      end
      else
      begin
        idle++;
        if (idle > timeout_lp)
          report_timeout("a link word");
      end
    end
  endtask

  initial
  begin
    void'($urandom(1));
    rst_i = 1'b1;
    v_i = 1'b0;
    data_i = '0;
    ready_and_i = 1'b0;
    stall_cnt = 0;
    $readmemh("ser_link_testdata.txt", stim_mem);
    check_reset_state();
    fork
      drive_inputs();
      receive_outputs();
      watch_link();
    join
    check_value("words received", num_trans_lp, rx_cnt);
    // The long stalls in the data must have parked the link at least once
    check_value("link stall seen", 1, stall_cnt > 0);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: ser_link_testdata.txt
// Columns: wide word, idle cycles before it, output stall cycles (all hex)
// Word 0 of the wide word sits in the low bits
03020100 0 0
07060504 0 0
a5a55a5a 1 0
deadbeef 0 2
0badf00d 0 0
12345678 2 0
ffffffff 0 c
00000000 0 0
89abcdef 0 0
fedcba98 3 1
c3c3c3c3 0 10
3c3c3c3c 0 0
55aa55aa 0 0
13579bdf 1 5
2468ace0 0 0
80000001 0 0

// File: ser_link_top.sv
/*
 * Narrow-link gearbox top level
 * A wide word is sent one narrow word per cycle across an internal link and
 * rebuilt on the far side. The link words are brought out for monitoring.
 */
`timescale 1ns/10ps
`include "ser_link_config.svh"

module ser_link_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  v_i,
  input  ser_link_pkg::wide_t   data_i,
  output logic                  ready_and_o,
  output logic                  v_o,
  output ser_link_pkg::wide_t   data_o,
  input  logic                  ready_and_i,
  output logic                  link_v_o,
  output ser_link_pkg::narrow_t link_data_o
);

  logic [`SL_ELS-1:0] count_oh;
  logic               load_out;
  logic               out_full;

  // Link advance and the link word leave on the monitor ports directly
  link_ctrl link_ctrl_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .v_i         (v_i),
    .ready_and_i (ready_and_i),
    .out_full_i  (out_full),
    .ready_and_o (ready_and_o),
    .link_adv_o  (link_v_o),
    .last_word_o (),
    .count_oh_o  (count_oh),
    .load_out_o  (load_out)
  );

  piso_word_sel #(
    .width_p    (`SL_WIDTH),
    .els_p      (`SL_ELS),
    .hi_to_lo_p (`SL_HI_TO_LO)
  ) piso_word_sel_inst (
    .data_i     (data_i),
    .count_oh_i (count_oh),
    .word_o     (link_data_o)
  );

  // Far side of the link, fed by the same counter that drove the select
  sipo_word_capture #(
    .width_p (`SL_WIDTH),
    .els_p   (`SL_ELS)
  ) sipo_word_capture_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .link_adv_i  (link_v_o),
    .count_oh_i  (count_oh),
    .word_i      (link_data_o),
    .load_out_i  (load_out),
    .ready_and_i (ready_and_i),
    .v_o         (v_o),
    .data_o      (data_o),
    .out_full_o  (out_full)
  );

endmodule

// File: sipo_word_capture.sv
/*
 * Deserializer word capture
 * Collects link words in an assembly register and writes the complete wide
 * word into the output register together with the last link word.
 * The output register holds its word and valid until the consumer is ready.
 */
`timescale 1ns/10ps
`include "ser_link_config.svh"

module sipo_word_capture #(
  parameter int width_p = `SL_WIDTH,
  parameter int els_p   = `SL_ELS
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  link_adv_i,
  input  logic [els_p-1:0]      count_oh_i,
  input  ser_link_pkg::narrow_t word_i,
  input  logic                  load_out_i,
  input  logic                  ready_and_i,
  output logic                  v_o,
  output ser_link_pkg::wide_t   data_o,
  output logic                  out_full_o
);

  // Link order must be undone here so that data_o matches the sent word
  localparam bit hi_to_lo_lp = (`SL_HI_TO_LO != 0);

  logic [els_p-1:0]              slot_oh;
  logic [els_p-1:0][width_p-1:0] asm_r;
  logic [els_p-1:0][width_p-1:0] asm_merged;

  // Map the counter position to the slot the word belongs in
  for (genvar i = 0; i < els_p; i++)
  begin : g_slot
    if (hi_to_lo_lp)
    begin : g_mirror
      assign slot_oh[i] = count_oh_i[els_p-1-i];
    end
    else
    begin : g_direct
      assign slot_oh[i] = count_oh_i[i];
    end
  end

  // Assembly contents with the current link word already in place
  // The output register takes this view so the last word skips the assembly
  always_comb
  begin
    for (int i = 0; i < els_p; i++)
    begin
      asm_merged[i] = (link_adv_i & slot_oh[i]) ? word_i : asm_r[i];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (link_adv_i)
      asm_r <= asm_merged;
  end

  // Load is only given when the register is empty or being read
  always_ff @(posedge clk_i)
  begin
    if (load_out_i)
      data_o <= asm_merged;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      v_o <= 1'b0;
    else if (load_out_i)
      v_o <= 1'b1;
    else if (ready_and_i)
      v_o <= 1'b0;
  end

  assign out_full_o = v_o;

endmodule
